//--- phy_tx_top.f
design/phy_tx_pkg.sv
design/arb_if.sv
design/tx_sym_if.sv
design/ctrl_decoder.sv
design/arb_que.sv
design/tx_arbiter.sv
design/tx_framer.sv
design/phy_tx_top.sv
testbench/phy_tx_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the phy_tx testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f phy_tx_top.f --top-module phy_tx_tb -o phy_tx_sim
./obj_dir/phy_tx_sim | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- testbench/phy_tx_golden.txt
// stimulus entry: valid_class_header_dataword, an entry with valid 0 drives data_word
// and waits until the header value gives the total number of symbols received
// expected entry: sym_word, first entry: stimulus count in [31:16], expected count in [15:0]
00_0022_002D
// packet framing, one data word per data symbol
1_6_0000_0000 0_0_0001_0000 0_0_0002_1111 0_0_0003_2222 0_0_0004_3333 0_0_0005_0000
// three ack words in arrival order
1_0_A001_0000 1_0_A002_0000 1_0_A003_0000 0_0_0008_0000
// control words queued in reverse priority during a packet
1_6_0000_00C0 0_0_0009_00C0
1_5_B006_00C0 1_4_B005_00C0 1_3_B004_00C0 1_2_B003_00C0 1_0_B002_00C0 1_1_B001_00C0
0_0_0013_00C0
// control words and packet requests pending together
1_6_0000_00D0 0_0_0014_00D0
1_6_0000_00D0 1_1_C001_00D0 1_6_0000_00D0 1_5_C006_00D0 0_0_0024_00D0
// five res1 words, the fifth finds the queue full
1_6_0000_00E0 0_0_0025_00E0
1_3_E001_00E0 1_3_E002_00E0 1_3_E003_00E0 1_3_E004_00E0 1_3_E005_00E0 0_0_002D_00E0
// expected symbols
7_0000 8_1111 8_2222 8_3333 9_0000
2_A001 2_A002 2_A003
7_0000 8_00C0 8_00C0 8_00C0 9_0000
1_B001 2_B002 3_B003 4_B004 5_B005 6_B006
7_0000 8_00D0 8_00D0 8_00D0 9_0000 1_C001
7_0000 8_00D0 8_00D0 8_00D0 9_0000 6_C006
7_0000 8_00D0 8_00D0 8_00D0 9_0000
7_0000 8_00E0 8_00E0 8_00E0 9_0000
4_E001 4_E002 4_E003 4_E004

//--- testbench/phy_tx_tb.sv
`timescale 1ns/100ps

module phy_tx_tb import phy_tx_pkg::*; ();

    localparam int GOLDEN_ROWS = 256;

    logic        CLK;
    logic        nRST;
    logic        rx_valid;
    ctrl_class_t rx_class;
    hdr_t        rx_header;
    hdr_t        data_word;
    logic        tx_valid;
    sym_sel_t    tx_sym;
    hdr_t        tx_word;
    logic        drop_err;

    logic [39:0] golden [GOLDEN_ROWS];
    logic [39:0] exp_row;
    int          n_stim;
    int          n_exp;
    int          rcv_cnt;
    int          err_cnt;

    phy_tx_top dut_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .rx_valid  (rx_valid),
        .rx_class  (rx_class),
        .rx_header (rx_header),
        .data_word (data_word),
        .tx_valid  (tx_valid),
        .tx_sym    (tx_sym),
        .tx_word   (tx_word),
        .drop_err  (drop_err)
    );

    always #50 CLK = ~CLK;

    task automatic check_sym(input sym_sel_t want, input sym_sel_t got, input int idx);
        if (got !== want) begin
            $display("Error tx_sym at symbol %0d: expected %h, actual %h", idx, want, got);
            err_cnt++;
        end
    endtask

    task automatic check_word(input hdr_t want, input hdr_t got, input int idx);
        if (got !== want) begin
            $display("Error tx_word at symbol %0d: expected %h, actual %h", idx, want, got);
            err_cnt++;
        end
    endtask

    task automatic compare_flag(input logic want, input logic got, input string name);
        if (got !== want) begin
            $display("Error %s: expected %h, actual %h", name, want, got);
            err_cnt++;
        end
    endtask

    task automatic report_counts();
        $display("%0d errors, %0d of %0d symbols received", err_cnt, rcv_cnt, n_exp);
    endtask

    // ################################################
    // output monitor
    // ################################################
    always @(negedge CLK) begin
        if (tx_valid) begin
            if (rcv_cnt < n_exp) begin
                exp_row = golden[8'(1 + n_stim + rcv_cnt)];
                check_sym(sym_sel_t'(exp_row[19:16]), tx_sym, rcv_cnt);
                check_word(exp_row[15:0], tx_word, rcv_cnt);
            end else begin
                $display("Unexpected symbol %h after the last expected one", tx_sym);
                err_cnt++;
            end
            rcv_cnt++;
        end
    end

    initial begin : watchdog
        int limit;
        @(posedge CLK);
        limit = n_stim + n_exp * SYM_CYCLES * 4 + 200;
        repeat (limit) @(posedge CLK);
        $display("Timeout after %0d cycles, %0d symbols still missing", limit, n_exp - rcv_cnt);
        report_counts();
        $display("Errors found");
        $finish;
    end

    // ################################################
    // stimulus
    // ################################################
    initial begin
        logic [39:0] row;
        CLK       = 1'b0;
        nRST      = 1'b0;
        rx_valid  = 1'b0;
        rx_class  = CLS_ACK;
        rx_header = '0;
        data_word = '0;
        rcv_cnt   = 0;
        err_cnt   = 0;
        $readmemh("testbench/phy_tx_golden.txt", golden);
        n_stim = int'(golden[0][31:16]);
        n_exp  = int'(golden[0][15:0]);

        // outputs stay quiet in reset
        repeat (15) begin
            @(negedge CLK);
            compare_flag(1'b0, tx_valid, "tx_valid");
            compare_flag(1'b0, drop_err, "drop_err");
        end
        @(posedge CLK);
        nRST <= 1'b1;
        repeat (8) @(posedge CLK);

        for (int i = 0; i < n_stim; i++) begin
            row = golden[8'(1 + i)];
            @(posedge CLK);
            rx_valid  <= row[36];
            rx_class  <= ctrl_class_t'(row[34:32]);
            rx_header <= row[31:16];
            data_word <= row[15:0];
            // idle entry holds data_word until the symbol total is reached
            if (!row[36]) begin
                wait (rcv_cnt >= int'(row[31:16]));
            end
        end

        // no further symbols without stimulus
        repeat (SYM_CYCLES * 20) @(posedge CLK);
        compare_flag(1'b1, drop_err, "drop_err");
        report_counts();
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- design/phy_tx_top.sv
`timescale 1ns/100ps

module phy_tx_top import phy_tx_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        rx_valid,
    input  ctrl_class_t rx_class,
    input  hdr_t        rx_header,
    input  hdr_t        data_word,
    output logic        tx_valid,
    output sym_sel_t    tx_sym,
    output hdr_t        tx_word,
    output logic        drop_err
);

    arb_if    arb_bus ();
    tx_sym_if sym_bus ();

    ctrl_decoder decoder_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .rx_valid  (rx_valid),
        .rx_class  (rx_class),
        .rx_header (rx_header),
        .drop_err  (drop_err),
        .arb       (arb_bus.dec)
    );

    tx_arbiter arbiter_i (
        .CLK  (CLK),
        .nRST (nRST),
        .arb  (arb_bus.arb),
        .sym  (sym_bus.src)
    );

    tx_framer framer_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .data_word (data_word),
        .sym       (sym_bus.snk),
        .tx_valid  (tx_valid),
        .tx_sym    (tx_sym),
        .tx_word   (tx_word)
    );

endmodule

//--- design/tx_framer.sv
`timescale 1ns/100ps

module tx_framer import phy_tx_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  hdr_t     data_word,
    tx_sym_if.snk    sym,
    output logic     tx_valid,
    output sym_sel_t tx_sym,
    output hdr_t     tx_word
);

    logic      busy;
    cyc_cnt_t  cyc_cnt;
    word_cnt_t word_cnt;
    sym_sel_t  sel_q;
    hdr_t      word_q;

    assign sym.done        = busy && (cyc_cnt == '0);
    assign sym.get_data    = sym.done && (sel_q == SYM_START || sel_q == SYM_DATA);
    assign sym.packet_done = (word_cnt == word_cnt_t'(PKT_WORDS));

    assign tx_valid = sym.done;
    assign tx_sym   = sel_q;
    assign tx_word  = word_q;

    // symbol timer
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy     <= 1'b0;
            cyc_cnt  <= '0;
            sel_q    <= SYM_NONE;
            word_cnt <= '0;
        end else begin
            if (sym.start) begin
                busy    <= 1'b1;
                cyc_cnt <= cyc_cnt_t'(SYM_CYCLES - 1);
                sel_q   <= sym.comma_sel;
            end else if (sym.done) begin
                busy <= 1'b0;
            end else if (busy) begin
                cyc_cnt <= cyc_cnt - 1'b1;
            end

            // data symbols sent in this packet
            if (sym.start && sym.comma_sel == SYM_START) begin
                word_cnt <= '0;
            end else if (sym.done && sel_q == SYM_DATA) begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (sym.start) begin
            word_q <= (sym.comma_sel == SYM_DATA) ? data_word : sym.header;
        end
    end

endmodule

//--- design/tx_arbiter.sv
`timescale 1ns/100ps

module tx_arbiter import phy_tx_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    arb_if.arb    arb,
    tx_sym_if.src sym
);

    typedef enum logic [2:0] {
        IDLE, SENDING_COMMA, SENDING_START, STALL_DATA_SEND, SENDING_DATA, SENDING_END
    } arb_state_t;

    arb_state_t state, n_state;
    logic       ctrl_turn, ctrl_turn_n;

    logic nack_pop, ack_pop, res0_pop, res1_pop, res2_pop, res3_pop;
    hdr_t nack_head, ack_head, res0_head, res1_head, res2_head, res3_head;
    cnt_t nack_cnt, ack_cnt, res0_cnt, res1_cnt, res2_cnt, res3_cnt;

    cnt_t data_cnt;
    logic data_pop;

    // ################################################
    // control queues
    // ################################################
    arb_que nack (.CLK(CLK), .nRST(nRST), .push(arb.nack_write), .pop(nack_pop),
                  .din(arb.rx_header), .dout(nack_head), .count(nack_cnt), .full(arb.nack_full));
    arb_que ack  (.CLK(CLK), .nRST(nRST), .push(arb.ack_write), .pop(ack_pop),
                  .din(arb.rx_header), .dout(ack_head), .count(ack_cnt), .full(arb.ack_full));
    arb_que res0 (.CLK(CLK), .nRST(nRST), .push(arb.rs0_write), .pop(res0_pop),
                  .din(arb.rx_header), .dout(res0_head), .count(res0_cnt), .full(arb.rs0_full));
    arb_que res1 (.CLK(CLK), .nRST(nRST), .push(arb.rs1_write), .pop(res1_pop),
                  .din(arb.rx_header), .dout(res1_head), .count(res1_cnt), .full(arb.rs1_full));
    arb_que res2 (.CLK(CLK), .nRST(nRST), .push(arb.rs2_write), .pop(res2_pop),
                  .din(arb.rx_header), .dout(res2_head), .count(res2_cnt), .full(arb.rs2_full));
    arb_que res3 (.CLK(CLK), .nRST(nRST), .push(arb.rs3_write), .pop(res3_pop),
                  .din(arb.rx_header), .dout(res3_head), .count(res3_cnt), .full(arb.rs3_full));

    // pending packet requests
    assign arb.data_full = (data_cnt == cnt_t'(QUE_DEPTH));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            ctrl_turn <= 1'b0;
            data_cnt  <= '0;
        end else begin
            state     <= n_state;
            ctrl_turn <= ctrl_turn_n;
            if (arb.data_write && !data_pop && !arb.data_full) begin
                data_cnt <= data_cnt + 1'b1;
            end else if (data_pop && !arb.data_write) begin
                data_cnt <= data_cnt - 1'b1;
            end
        end
    end

    // ################################################
    // arbitration FSM
    // ################################################
    always_comb begin
        n_state       = state;
        ctrl_turn_n   = ctrl_turn;
        sym.start     = 1'b0;
        sym.comma_sel = SYM_NONE;
        sym.header    = '0;
        {nack_pop, ack_pop, res0_pop, res1_pop, res2_pop, res3_pop} = '0;
        data_pop      = 1'b0;

        case (state)
            IDLE: begin
                ctrl_turn_n = !ctrl_turn;
                if (ctrl_turn) begin
                    sym.start = 1'b1;
                    n_state   = SENDING_COMMA;
                    if (nack_cnt != '0) begin
                        nack_pop = 1'b1;
                        {sym.comma_sel, sym.header} = {SYM_NACK, nack_head};
                    end else if (ack_cnt != '0) begin
                        ack_pop = 1'b1;
                        {sym.comma_sel, sym.header} = {SYM_ACK, ack_head};
                    end else if (res0_cnt != '0) begin
                        res0_pop = 1'b1;
                        {sym.comma_sel, sym.header} = {SYM_RES0, res0_head};
                    end else if (res1_cnt != '0) begin
                        res1_pop = 1'b1;
                        {sym.comma_sel, sym.header} = {SYM_RES1, res1_head};
                    end else if (res2_cnt != '0) begin
                        res2_pop = 1'b1;
                        {sym.comma_sel, sym.header} = {SYM_RES2, res2_head};
                    end else if (res3_cnt != '0) begin
                        res3_pop = 1'b1;
                        {sym.comma_sel, sym.header} = {SYM_RES3, res3_head};
                    end else begin
                        // nothing queued this turn
                        sym.start = 1'b0;
                        n_state   = IDLE;
                    end
                end else if (data_cnt != '0) begin
                    data_pop      = 1'b1;
                    sym.start     = 1'b1;
                    sym.comma_sel = SYM_START;
                    n_state       = SENDING_START;
                end
            end
            SENDING_COMMA, SENDING_END: begin
                if (sym.done) begin
                    n_state = IDLE;
                end
            end
            SENDING_START, SENDING_DATA: begin
                if (sym.get_data) begin
                    n_state = STALL_DATA_SEND;
                end
            end
            STALL_DATA_SEND: begin
                sym.start     = 1'b1;
                sym.comma_sel = sym.packet_done ? SYM_END : SYM_DATA;
                n_state       = sym.packet_done ? SENDING_END : SENDING_DATA;
            end
            default: n_state = IDLE;
        endcase
    end

endmodule

//--- design/arb_que.sv
`timescale 1ns/100ps

module arb_que import phy_tx_pkg::*; (
    input  logic CLK,
    input  logic nRST,
    input  logic push,
    input  logic pop,
    input  hdr_t din,
    output hdr_t dout,
    output cnt_t count,
    output logic full
);

    hdr_t     mem [QUE_DEPTH];
    que_ptr_t wptr;
    que_ptr_t rptr;
    logic     do_push;
    logic     do_pop;

    function automatic que_ptr_t ptr_inc(input que_ptr_t p);
        return (p == que_ptr_t'(QUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full    = (count == cnt_t'(QUE_DEPTH));
    assign do_push = push && !full;
    assign do_pop  = pop && (count != '0);
    // head entry
    assign dout    = mem[rptr];

    always_ff @(posedge CLK) begin
        if (do_push) begin
            mem[wptr] <= din;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wptr <= ptr_inc(wptr);
            end
            if (do_pop) begin
                rptr <= ptr_inc(rptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- design/ctrl_decoder.sv
`timescale 1ns/100ps

module ctrl_decoder import phy_tx_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        rx_valid,
    input  ctrl_class_t rx_class,
    input  hdr_t        rx_header,
    output logic        drop_err,
    arb_if.dec          arb
);

    logic        valid_q;
    ctrl_class_t class_q;
    hdr_t        header_q;
    logic        class_full;
    logic        accept;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q  <= 1'b0;
            drop_err <= 1'b0;
        end else begin
            valid_q <= rx_valid;
            // sticky until reset
            if (valid_q && class_full) begin
                drop_err <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        class_q  <= rx_class;
        header_q <= rx_header;
    end

    // full flag of the target queue
    always_comb begin
        case (class_q)
            CLS_ACK:  class_full = arb.ack_full;
            CLS_NACK: class_full = arb.nack_full;
            CLS_RES0: class_full = arb.rs0_full;
            CLS_RES1: class_full = arb.rs1_full;
            CLS_RES2: class_full = arb.rs2_full;
            CLS_RES3: class_full = arb.rs3_full;
            CLS_DATA: class_full = arb.data_full;
            default:  class_full = 1'b0;
        endcase
    end

    assign accept = valid_q && !class_full;

    assign arb.ack_write  = accept && (class_q == CLS_ACK);
    assign arb.nack_write = accept && (class_q == CLS_NACK);
    assign arb.rs0_write  = accept && (class_q == CLS_RES0);
    assign arb.rs1_write  = accept && (class_q == CLS_RES1);
    assign arb.rs2_write  = accept && (class_q == CLS_RES2);
    assign arb.rs3_write  = accept && (class_q == CLS_RES3);
    assign arb.data_write = accept && (class_q == CLS_DATA);
    assign arb.rx_header  = header_q;

endmodule

//--- design/tx_sym_if.sv
`timescale 1ns/100ps

interface tx_sym_if import phy_tx_pkg::*; ();

    sym_sel_t comma_sel;
    logic     start;
    hdr_t     header;

    logic     done;
    logic     get_data;
    logic     packet_done;

    modport src (
        output comma_sel, start, header,
        input  done, get_data, packet_done
    );

    modport snk (
        input  comma_sel, start, header,
        output done, get_data, packet_done
    );

endinterface

//--- design/arb_if.sv
`timescale 1ns/100ps

interface arb_if import phy_tx_pkg::*; ();

    // one-hot write strobes
    logic ack_write, nack_write;
    logic rs0_write, rs1_write, rs2_write, rs3_write;
    logic data_write;
    hdr_t rx_header;

    // queue status back to the decoder
    logic ack_full, nack_full;
    logic rs0_full, rs1_full, rs2_full, rs3_full;
    logic data_full;

    modport dec (
        output ack_write, nack_write, rs0_write, rs1_write, rs2_write, rs3_write,
        output data_write, rx_header,
        input  ack_full, nack_full, rs0_full, rs1_full, rs2_full, rs3_full, data_full
    );

    modport arb (
        input  ack_write, nack_write, rs0_write, rs1_write, rs2_write, rs3_write,
        input  data_write, rx_header,
        output ack_full, nack_full, rs0_full, rs1_full, rs2_full, rs3_full, data_full
    );

endinterface

//--- design/phy_tx_pkg.sv
package phy_tx_pkg;

    // ################################################
    // sizing
    // ################################################
    localparam int QUE_DEPTH  = 4;
    localparam int PKT_WORDS  = 3;
    localparam int SYM_CYCLES = 2;

    localparam int CNT_W  = $clog2(QUE_DEPTH + 1);
    localparam int PTR_W  = $clog2(QUE_DEPTH);
    localparam int CYC_W  = $clog2(SYM_CYCLES + 1);
    localparam int WCNT_W = $clog2(PKT_WORDS + 1);

    // ################################################
    // types
    // ################################################
    typedef logic [15:0]       hdr_t;
    typedef logic [CNT_W-1:0]  cnt_t;
    typedef logic [PTR_W-1:0]  que_ptr_t;
    typedef logic [CYC_W-1:0]  cyc_cnt_t;
    typedef logic [WCNT_W-1:0] word_cnt_t;

    // received word class
    // CLS_DATA asks for one packet
    typedef enum logic [2:0] {
        CLS_ACK, CLS_NACK, CLS_RES0, CLS_RES1, CLS_RES2, CLS_RES3, CLS_DATA
    } ctrl_class_t;

    // symbol kind on the output stream
    typedef enum logic [3:0] {
        SYM_NONE, SYM_NACK, SYM_ACK,
        SYM_RES0, SYM_RES1, SYM_RES2, SYM_RES3,
        SYM_START, SYM_DATA, SYM_END
    } sym_sel_t;

endpackage
